// File: Bender.yml
package:
  name: bpu

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/bpu_pkg.sv
      - hw/bpu/bpu_table.sv
      - hw/bpu/bpu_ras.sv
      - hw/bpu/bpu_fetch_select.sv
      - hw/bpu/bpu_resolve.sv
      - hw/bpu/bpu_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/bpu_clock_gen.sv
      - verif/bpu_tb.sv

// File: common/bpu_config.svh
// table size follows BPU_INDEX_BITS; RAS_DEPTH must equal 2**RAS_PTR_BITS for the wrap to work
`ifndef BPU_CONFIG_SVH
`define BPU_CONFIG_SVH

// table index from fetch address bits [BPU_INDEX_BITS+1:2]
`define BPU_INDEX_BITS 6

// tag bits sit just above the index
`define BPU_TAG_BITS 8

// return address stack
`define RAS_DEPTH 8
`define RAS_PTR_BITS 3

`endif

// File: common/bpu_pkg.sv
// branch kinds and counter states shared by the predictor; encodings are fixed at 2 bits
package bpu_pkg;

  // kind of a resolved or stored branch
  typedef enum logic [1:0]
  {
    BR_COND   = 2'b00,
    BR_CALL   = 2'b01,
    BR_RETURN = 2'b10,
    BR_JUMP   = 2'b11
  } branch_kind_e;

  // 2-bit saturating counter that predicts taken in the upper half
  typedef enum logic [1:0]
  {
    STRONG_NOT_TAKEN = 2'b00,
    WEAK_NOT_TAKEN   = 2'b01,
    WEAK_TAKEN       = 2'b10,
    STRONG_TAKEN     = 2'b11
  } pht_state_e;

endpackage

// File: hw/bpu/bpu_fetch_select.sv
// purely combinational; a group is 4 aligned 32-bit slots and all slots share one tag
`include "bpu_config.svh"

module bpu_fetch_select (
  input  logic [31:0]                 fetch_pc,
  output logic [`BPU_INDEX_BITS-1:0]  rd_index0,
  output logic [`BPU_INDEX_BITS-1:0]  rd_index1,
  output logic [`BPU_INDEX_BITS-1:0]  rd_index2,
  output logic [`BPU_INDEX_BITS-1:0]  rd_index3,
  output logic [`BPU_TAG_BITS-1:0]    rd_tag,
  input  logic [3:0]                  rd_hit,
  input  logic [3:0]                  rd_taken,
  input  bpu_pkg::branch_kind_e       rd_kind0,
  input  bpu_pkg::branch_kind_e       rd_kind1,
  input  bpu_pkg::branch_kind_e       rd_kind2,
  input  bpu_pkg::branch_kind_e       rd_kind3,
  input  logic [31:0]                 rd_target0,
  input  logic [31:0]                 rd_target1,
  input  logic [31:0]                 rd_target2,
  input  logic [31:0]                 rd_target3,
  input  logic [31:0]                 ras_top,
  input  logic                        ras_empty,
  output logic [31:0]                 next_pc,
  output logic [3:0]                  slot_valid,
  output logic [3:0]                  slot_is_jump
);

  logic [31:0]           group_base;
  logic [3:0]            group_mask;
  logic [3:0]            cand;
  logic [3:0]            first;
  bpu_pkg::branch_kind_e sel_kind;
  logic [31:0]           sel_target;

  assign group_base = {fetch_pc[31:4], 4'b0000};
  assign rd_tag     = fetch_pc[`BPU_INDEX_BITS+`BPU_TAG_BITS+1:`BPU_INDEX_BITS+2];

  // slots differ only in the two low index bits
  assign rd_index0 = {fetch_pc[`BPU_INDEX_BITS+1:4], 2'd0};
  assign rd_index1 = {fetch_pc[`BPU_INDEX_BITS+1:4], 2'd1};
  assign rd_index2 = {fetch_pc[`BPU_INDEX_BITS+1:4], 2'd2};
  assign rd_index3 = {fetch_pc[`BPU_INDEX_BITS+1:4], 2'd3};

  // keep slots at or after the entry offset
  assign group_mask = 4'b1111 << fetch_pc[3:2];
  assign cand       = group_mask & rd_hit & rd_taken;

  // lowest set bit wins
  assign first = cand & (~cand + 4'd1);

  // with no winner first-1 is all ones, so the full mask falls out
  assign slot_valid   = group_mask & (first | (first - 4'd1));
  assign slot_is_jump = first;

  always_comb
  begin
    sel_kind   = bpu_pkg::BR_COND;
    sel_target = rd_target0;
    if (first[1])
    begin
      sel_kind   = rd_kind1;
      sel_target = rd_target1;
    end
    else if (first[2])
    begin
      sel_kind   = rd_kind2;
      sel_target = rd_target2;
    end
    else if (first[3])
    begin
      sel_kind   = rd_kind3;
      sel_target = rd_target3;
    end
    else if (first[0])
      sel_kind = rd_kind0;
  end

  always_comb
  begin
    if (first == 4'b0000)
      next_pc = group_base + 32'd16;
    else if (sel_kind == bpu_pkg::BR_RETURN && !ras_empty)
      next_pc = ras_top;
    else
      next_pc = sel_target;
  end

endmodule

// File: hw/bpu/bpu_ras.sv
// circular return stack; push wins if push and pop arrive together, full push drops the oldest
`include "bpu_config.svh"

module bpu_ras (
  input  logic        clk,
  input  logic        reset,
  input  logic        push,
  input  logic        pop,
  input  logic [31:0] push_addr,
  output logic [31:0] top_addr,
  output logic        empty
);

  logic [31:0]              mem_q [`RAS_DEPTH];
  logic [`RAS_PTR_BITS-1:0] ptr_q;
  logic [`RAS_PTR_BITS:0]   count_q;
  logic [`RAS_PTR_BITS-1:0] top_ptr;
  logic                     full;

  // ptr_q points at the next free slot
  assign top_ptr  = ptr_q - `RAS_PTR_BITS'(1);
  assign top_addr = mem_q[top_ptr];
  assign empty    = (count_q == '0);
  assign full     = (count_q == (`RAS_PTR_BITS+1)'(`RAS_DEPTH));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ptr_q   <= '0;
      count_q <= '0;
    end
    else if (push)
    begin
      ptr_q <= ptr_q + `RAS_PTR_BITS'(1);
      // wrap over the oldest entry once full
      if (!full)
        count_q <= count_q + 1'b1;
    end
    else if (pop && !empty)
    begin
      ptr_q   <= top_ptr;
      count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem_q[ptr_q] <= push_addr;
  end

endmodule

// File: hw/bpu/bpu_resolve.sv
// report 0 is older; exceptions must already be filtered out of ex*_valid by execute
module bpu_resolve (
  input  logic                  ex0_valid,
  input  logic [31:0]           ex0_pc,
  input  logic                  ex0_taken,
  input  logic [31:0]           ex0_target,
  input  bpu_pkg::branch_kind_e ex0_kind,
  input  logic                  ex0_mispredict,
  input  logic                  ex1_valid,
  input  logic [31:0]           ex1_pc,
  input  logic                  ex1_taken,
  input  logic [31:0]           ex1_target,
  input  bpu_pkg::branch_kind_e ex1_kind,
  input  logic                  ex1_mispredict,
  output logic                  flush,
  output logic [31:0]           flush_pc,
  output logic                  wr0_en,
  output logic                  wr1_en,
  output logic                  ras_push,
  output logic                  ras_pop,
  output logic [31:0]           ras_push_addr
);

  logic        flush0;
  logic        flush1;
  logic        keep1;
  logic [31:0] redirect0;
  logic [31:0] redirect1;
  logic        push0;
  logic        pop0;
  logic        push1;
  logic        pop1;

  assign redirect0 = ex0_taken ? ex0_target : ex0_pc + 32'd4;
  assign redirect1 = ex1_taken ? ex1_target : ex1_pc + 32'd4;

  // report 1 is wrong-path once report 0 flushes
  assign flush0 = ex0_valid && ex0_mispredict;
  assign keep1  = ex1_valid && !flush0;
  assign flush1 = keep1 && ex1_mispredict;

  assign flush    = flush0 || flush1;
  assign flush_pc = flush0 ? redirect0 : redirect1;

  assign wr0_en = ex0_valid;
  assign wr1_en = keep1;

  assign push0 = ex0_valid && ex0_taken && (ex0_kind == bpu_pkg::BR_CALL);
  assign pop0  = ex0_valid && ex0_taken && (ex0_kind == bpu_pkg::BR_RETURN);
  assign push1 = keep1 && ex1_taken && (ex1_kind == bpu_pkg::BR_CALL);
  assign pop1  = keep1 && ex1_taken && (ex1_kind == bpu_pkg::BR_RETURN);

  // one stack op per cycle with the older report first
  assign ras_push      = push0 || (!pop0 && push1);
  assign ras_pop       = pop0 || (!push0 && pop1);
  assign ras_push_addr = push0 ? ex0_pc + 32'd4 : ex1_pc + 32'd4;

endmodule

// File: hw/bpu/bpu_table.sv
// direct mapped BTB plus counters; only valid bits reset, port 1 overrides port 0 on the same index
`include "bpu_config.svh"

module bpu_table (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`BPU_INDEX_BITS-1:0]  rd_index0,
  input  logic [`BPU_INDEX_BITS-1:0]  rd_index1,
  input  logic [`BPU_INDEX_BITS-1:0]  rd_index2,
  input  logic [`BPU_INDEX_BITS-1:0]  rd_index3,
  input  logic [`BPU_TAG_BITS-1:0]    rd_tag,
  output logic [3:0]                  rd_hit,
  output logic [3:0]                  rd_taken,
  output bpu_pkg::branch_kind_e       rd_kind0,
  output bpu_pkg::branch_kind_e       rd_kind1,
  output bpu_pkg::branch_kind_e       rd_kind2,
  output bpu_pkg::branch_kind_e       rd_kind3,
  output logic [31:0]                 rd_target0,
  output logic [31:0]                 rd_target1,
  output logic [31:0]                 rd_target2,
  output logic [31:0]                 rd_target3,
  input  logic                        wr0_en,
  input  logic [31:0]                 wr0_pc,
  input  logic                        wr0_taken,
  input  logic [31:0]                 wr0_target,
  input  bpu_pkg::branch_kind_e       wr0_kind,
  input  logic                        wr1_en,
  input  logic [31:0]                 wr1_pc,
  input  logic                        wr1_taken,
  input  logic [31:0]                 wr1_target,
  input  bpu_pkg::branch_kind_e       wr1_kind
);

  localparam int unsigned entries = 1 << `BPU_INDEX_BITS;

  logic [entries-1:0]        valid_q;
  logic [`BPU_TAG_BITS-1:0]  tag_q    [entries];
  bpu_pkg::branch_kind_e     kind_q   [entries];
  logic [31:2]               target_q [entries];
  bpu_pkg::pht_state_e       ctr_q    [entries];

  logic [`BPU_INDEX_BITS-1:0] rd_index [4];

  logic                       wr_en     [2];
  logic                       wr_taken  [2];
  logic [31:0]                wr_pc     [2];
  logic [31:0]                wr_target [2];
  bpu_pkg::branch_kind_e      wr_kind   [2];
  logic [`BPU_INDEX_BITS-1:0] wr_index  [2];
  logic [`BPU_TAG_BITS-1:0]   wr_tag    [2];
  logic                       wr_hit    [2];

  // saturating step of a 2-bit counter
  function automatic bpu_pkg::pht_state_e ctr_step(input bpu_pkg::pht_state_e ctr,
                                                   input logic up);
    bpu_pkg::pht_state_e nxt;
    nxt = ctr;
    if (up && ctr != bpu_pkg::STRONG_TAKEN)
      nxt = bpu_pkg::pht_state_e'(ctr + 2'd1);
    else if (!up && ctr != bpu_pkg::STRONG_NOT_TAKEN)
      nxt = bpu_pkg::pht_state_e'(ctr - 2'd1);
    return nxt;
  endfunction

  assign rd_index[0] = rd_index0;
  assign rd_index[1] = rd_index1;
  assign rd_index[2] = rd_index2;
  assign rd_index[3] = rd_index3;

  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      rd_hit[i]   = valid_q[rd_index[i]] && (tag_q[rd_index[i]] == rd_tag);
      rd_taken[i] = (ctr_q[rd_index[i]] >= bpu_pkg::WEAK_TAKEN);
    end
  end

  assign rd_kind0   = kind_q[rd_index0];
  assign rd_kind1   = kind_q[rd_index1];
  assign rd_kind2   = kind_q[rd_index2];
  assign rd_kind3   = kind_q[rd_index3];
  assign rd_target0 = {target_q[rd_index0], 2'b00};
  assign rd_target1 = {target_q[rd_index1], 2'b00};
  assign rd_target2 = {target_q[rd_index2], 2'b00};
  assign rd_target3 = {target_q[rd_index3], 2'b00};

  assign wr_en[0]     = wr0_en;
  assign wr_pc[0]     = wr0_pc;
  assign wr_taken[0]  = wr0_taken;
  assign wr_target[0] = wr0_target;
  assign wr_kind[0]   = wr0_kind;
  assign wr_en[1]     = wr1_en;
  assign wr_pc[1]     = wr1_pc;
  assign wr_taken[1]  = wr1_taken;
  assign wr_target[1] = wr1_target;
  assign wr_kind[1]   = wr1_kind;

  // own hit test on the write address
  always_comb
  begin
    for (int p = 0; p < 2; p++)
    begin
      wr_index[p] = wr_pc[p][`BPU_INDEX_BITS+1:2];
      wr_tag[p]   = wr_pc[p][`BPU_INDEX_BITS+`BPU_TAG_BITS+1:`BPU_INDEX_BITS+2];
      wr_hit[p]   = valid_q[wr_index[p]] && (tag_q[wr_index[p]] == wr_tag[p]);
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      valid_q <= '0;
    else
    begin
      for (int p = 0; p < 2; p++)
        if (wr_en[p] && wr_taken[p])
          valid_q[wr_index[p]] <= 1'b1;
    end
  end

  // later port wins on the same index
  always_ff @(posedge clk)
  begin
    for (int p = 0; p < 2; p++)
    begin
      if (wr_en[p] && wr_taken[p])
      begin
        tag_q[wr_index[p]]    <= wr_tag[p];
        kind_q[wr_index[p]]   <= wr_kind[p];
        target_q[wr_index[p]] <= wr_target[p][31:2];
        ctr_q[wr_index[p]]    <= wr_hit[p] ? ctr_step(ctr_q[wr_index[p]], 1'b1)
                                           : bpu_pkg::WEAK_TAKEN;
      end
      else if (wr_en[p] && wr_hit[p])
        ctr_q[wr_index[p]] <= ctr_step(ctr_q[wr_index[p]], 1'b0);
    end
  end

endmodule

// File: hw/bpu/bpu_top.sv
// no handshake; lookup and flush are same-cycle, training shows up on the next cycle
`include "bpu_config.svh"

module bpu_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [31:0]           fetch_pc,
  output logic [31:0]           next_pc,
  output logic [3:0]            slot_valid,
  output logic [3:0]            slot_is_jump,
  input  logic                  ex0_valid,
  input  logic [31:0]           ex0_pc,
  input  logic                  ex0_taken,
  input  logic [31:0]           ex0_target,
  input  bpu_pkg::branch_kind_e ex0_kind,
  input  logic                  ex0_mispredict,
  input  logic                  ex1_valid,
  input  logic [31:0]           ex1_pc,
  input  logic                  ex1_taken,
  input  logic [31:0]           ex1_target,
  input  bpu_pkg::branch_kind_e ex1_kind,
  input  logic                  ex1_mispredict,
  output logic                  flush,
  output logic [31:0]           flush_pc
);

  logic [`BPU_INDEX_BITS-1:0] rd_index0;
  logic [`BPU_INDEX_BITS-1:0] rd_index1;
  logic [`BPU_INDEX_BITS-1:0] rd_index2;
  logic [`BPU_INDEX_BITS-1:0] rd_index3;
  logic [`BPU_TAG_BITS-1:0]   rd_tag;
  logic [3:0]                 rd_hit;
  logic [3:0]                 rd_taken;
  bpu_pkg::branch_kind_e      rd_kind0;
  bpu_pkg::branch_kind_e      rd_kind1;
  bpu_pkg::branch_kind_e      rd_kind2;
  bpu_pkg::branch_kind_e      rd_kind3;
  logic [31:0]                rd_target0;
  logic [31:0]                rd_target1;
  logic [31:0]                rd_target2;
  logic [31:0]                rd_target3;
  logic                       wr0_en;
  logic                       wr1_en;
  logic                       ras_push;
  logic                       ras_pop;
  logic [31:0]                ras_push_addr;
  logic [31:0]                ras_top;
  logic                       ras_empty;

  bpu_fetch_select u_fetch_select (
    .fetch_pc     (fetch_pc),
    .rd_index0    (rd_index0),
    .rd_index1    (rd_index1),
    .rd_index2    (rd_index2),
    .rd_index3    (rd_index3),
    .rd_tag       (rd_tag),
    .rd_hit       (rd_hit),
    .rd_taken     (rd_taken),
    .rd_kind0     (rd_kind0),
    .rd_kind1     (rd_kind1),
    .rd_kind2     (rd_kind2),
    .rd_kind3     (rd_kind3),
    .rd_target0   (rd_target0),
    .rd_target1   (rd_target1),
    .rd_target2   (rd_target2),
    .rd_target3   (rd_target3),
    .ras_top      (ras_top),
    .ras_empty    (ras_empty),
    .next_pc      (next_pc),
    .slot_valid   (slot_valid),
    .slot_is_jump (slot_is_jump)
  );

  // write data comes straight from the execute ports
  bpu_table u_table (
    .clk        (clk),
    .reset      (reset),
    .rd_index0  (rd_index0),
    .rd_index1  (rd_index1),
    .rd_index2  (rd_index2),
    .rd_index3  (rd_index3),
    .rd_tag     (rd_tag),
    .rd_hit     (rd_hit),
    .rd_taken   (rd_taken),
    .rd_kind0   (rd_kind0),
    .rd_kind1   (rd_kind1),
    .rd_kind2   (rd_kind2),
    .rd_kind3   (rd_kind3),
    .rd_target0 (rd_target0),
    .rd_target1 (rd_target1),
    .rd_target2 (rd_target2),
    .rd_target3 (rd_target3),
    .wr0_en     (wr0_en),
    .wr0_pc     (ex0_pc),
    .wr0_taken  (ex0_taken),
    .wr0_target (ex0_target),
    .wr0_kind   (ex0_kind),
    .wr1_en     (wr1_en),
    .wr1_pc     (ex1_pc),
    .wr1_taken  (ex1_taken),
    .wr1_target (ex1_target),
    .wr1_kind   (ex1_kind)
  );

  bpu_ras u_ras (
    .clk       (clk),
    .reset     (reset),
    .push      (ras_push),
    .pop       (ras_pop),
    .push_addr (ras_push_addr),
    .top_addr  (ras_top),
    .empty     (ras_empty)
  );

  bpu_resolve u_resolve (
    .ex0_valid      (ex0_valid),
    .ex0_pc         (ex0_pc),
    .ex0_taken      (ex0_taken),
    .ex0_target     (ex0_target),
    .ex0_kind       (ex0_kind),
    .ex0_mispredict (ex0_mispredict),
    .ex1_valid      (ex1_valid),
    .ex1_pc         (ex1_pc),
    .ex1_taken      (ex1_taken),
    .ex1_target     (ex1_target),
    .ex1_kind       (ex1_kind),
    .ex1_mispredict (ex1_mispredict),
    .flush          (flush),
    .flush_pc       (flush_pc),
    .wr0_en         (wr0_en),
    .wr1_en         (wr1_en),
    .ras_push       (ras_push),
    .ras_pop        (ras_pop),
    .ras_push_addr  (ras_push_addr)
  );

endmodule

// File: verif/bpu_clock_gen.sv
// free running 100 ns clock; synchronous active-high reset held for the first 5 rising edges
module bpu_clock_gen (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial
  begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: verif/bpu_tb.sv
// one row per cycle; expected values come from a model of the table and stack kept in step
`include "bpu_config.svh"

module bpu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [31:0]           fetch_pc;
    logic                  v0;
    logic [31:0]           pc0;
    logic                  t0;
    logic [31:0]           tgt0;
    bpu_pkg::branch_kind_e k0;
    logic                  m0;
    logic                  v1;
    logic [31:0]           pc1;
    logic                  t1;
    logic [31:0]           tgt1;
    bpu_pkg::branch_kind_e k1;
    logic                  m1;
    logic [31:0]           exp_next;
    logic [3:0]            exp_valid;
    logic [3:0]            exp_jump;
    logic                  exp_flush;
    logic [31:0]           exp_flush_pc;
  } row_t;

  localparam int entries = 1 << `BPU_INDEX_BITS;

  logic                  clk;
  logic                  reset;
  logic [31:0]           fetch_pc;
  logic [31:0]           next_pc;
  logic [3:0]            slot_valid;
  logic [3:0]            slot_is_jump;
  logic                  ex0_valid;
  logic [31:0]           ex0_pc;
  logic                  ex0_taken;
  logic [31:0]           ex0_target;
  bpu_pkg::branch_kind_e ex0_kind;
  logic                  ex0_mispredict;
  logic                  ex1_valid;
  logic [31:0]           ex1_pc;
  logic                  ex1_taken;
  logic [31:0]           ex1_target;
  bpu_pkg::branch_kind_e ex1_kind;
  logic                  ex1_mispredict;
  logic                  flush;
  logic [31:0]           flush_pc;

  row_t  rows[$];
  string names[$];

  // model state
  logic                     m_valid  [entries];
  logic [`BPU_TAG_BITS-1:0] m_tag    [entries];
  bpu_pkg::branch_kind_e    m_kind   [entries];
  logic [31:0]              m_target [entries];
  int                       m_ctr    [entries];
  logic [31:0]              m_stack  [`RAS_DEPTH];
  int                       m_sp;
  int                       m_count;

  int errors;
  int checks;
  int tests;
  int failed_tests;
  int test_errs;
  int cycles;
  int cycle_limit;

  bpu_clock_gen clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  bpu_top UUT (
    .clk            (clk),
    .reset          (reset),
    .fetch_pc       (fetch_pc),
    .next_pc        (next_pc),
    .slot_valid     (slot_valid),
    .slot_is_jump   (slot_is_jump),
    .ex0_valid      (ex0_valid),
    .ex0_pc         (ex0_pc),
    .ex0_taken      (ex0_taken),
    .ex0_target     (ex0_target),
    .ex0_kind       (ex0_kind),
    .ex0_mispredict (ex0_mispredict),
    .ex1_valid      (ex1_valid),
    .ex1_pc         (ex1_pc),
    .ex1_taken      (ex1_taken),
    .ex1_target     (ex1_target),
    .ex1_kind       (ex1_kind),
    .ex1_mispredict (ex1_mispredict),
    .flush          (flush),
    .flush_pc       (flush_pc)
  );

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      errors++;
      test_errs++;
    end
  endtask

  task automatic add_row(input string name, input row_t r);
    names.push_back(name);
    rows.push_back(r);
  endtask

  task automatic add_lookup(input string name, input logic [31:0] pc);
    row_t r;
    r = '0;
    r.fetch_pc = pc;
    add_row(name, r);
  endtask

  task automatic add_pair(input string name,
                          input logic [31:0] pc0, input logic t0, input logic [31:0] tgt0,
                          input bpu_pkg::branch_kind_e k0, input logic m0,
                          input logic v1, input logic [31:0] pc1, input logic t1,
                          input logic [31:0] tgt1, input bpu_pkg::branch_kind_e k1,
                          input logic m1);
    row_t r;
    r = '0;
    r.v0   = 1'b1;
    r.pc0  = pc0;
    r.t0   = t0;
    r.tgt0 = tgt0;
    r.k0   = k0;
    r.m0   = m0;
    r.v1   = v1;
    r.pc1  = pc1;
    r.t1   = t1;
    r.tgt1 = tgt1;
    r.k1   = k1;
    r.m1   = m1;
    add_row(name, r);
  endtask

  task automatic add_report(input string name, input logic [31:0] pc, input logic taken,
                            input logic [31:0] tgt, input bpu_pkg::branch_kind_e kind,
                            input logic mis);
    add_pair(name, pc, taken, tgt, kind, mis, 1'b0, '0, 1'b0, '0, bpu_pkg::BR_COND, 1'b0);
  endtask

  // index sits just above the word offset and the tag just above the index
  function automatic int index_of(input logic [31:0] pc);
    return pc[`BPU_INDEX_BITS+1:2];
  endfunction

  function automatic logic entry_hit(input logic [31:0] pc);
    return m_valid[index_of(pc)] &&
           m_tag[index_of(pc)] == pc[`BPU_INDEX_BITS+`BPU_TAG_BITS+1:`BPU_INDEX_BITS+2];
  endfunction

  task automatic predict(input logic [31:0] pc, output logic [31:0] nxt,
                         output logic [3:0] valid, output logic [3:0] jump);
    logic [31:0] base;
    int          idx;
    int          win;
    base  = {pc[31:4], 4'h0};
    win   = -1;
    valid = '0;
    jump  = '0;
    for (int s = pc[3:2]; s < 4; s++)
    begin
      if (win < 0)
      begin
        valid[s] = 1'b1;
        if (entry_hit(base + 4 * s) && m_ctr[index_of(base + 4 * s)] >= 2)
          win = s;
      end
    end
    nxt = base + 32'd16;
    if (win >= 0)
    begin
      jump[win] = 1'b1;
      idx = index_of(base + 4 * win);
      if (m_kind[idx] == bpu_pkg::BR_RETURN && m_count > 0)
        nxt = m_stack[(m_sp + `RAS_DEPTH - 1) % `RAS_DEPTH];
      else
        nxt = m_target[idx];
    end
  endtask

  task automatic write_entry(input logic [31:0] pc, input logic taken, input logic [31:0] tgt,
                             input bpu_pkg::branch_kind_e kind, input logic hit, input int ctr);
    int idx;
    idx = index_of(pc);
    if (taken)
    begin
      m_valid[idx]  = 1'b1;
      m_tag[idx]    = pc[`BPU_INDEX_BITS+`BPU_TAG_BITS+1:`BPU_INDEX_BITS+2];
      m_kind[idx]   = kind;
      m_target[idx] = tgt & ~32'd3;
      m_ctr[idx]    = hit ? ((ctr < 3) ? ctr + 1 : 3) : 2;
    end
    else if (hit)
      m_ctr[idx] = (ctr > 0) ? ctr - 1 : 0;
  endtask

  task automatic stack_op(input logic push, input logic pop, input logic [31:0] addr);
    if (push)
    begin
      m_stack[m_sp] = addr;
      m_sp = (m_sp + 1) % `RAS_DEPTH;
      if (m_count < `RAS_DEPTH)
        m_count++;
    end
    else if (pop && m_count > 0)
    begin
      m_sp = (m_sp + `RAS_DEPTH - 1) % `RAS_DEPTH;
      m_count--;
    end
  endtask

  task automatic train(input row_t r);
    logic keep1;
    logic hit0;
    logic hit1;
    int   ctr0;
    int   ctr1;
    keep1 = r.v1 && !(r.v0 && r.m0);
    // both ports see the state from before the edge
    hit0 = entry_hit(r.pc0);
    hit1 = entry_hit(r.pc1);
    ctr0 = m_ctr[index_of(r.pc0)];
    ctr1 = m_ctr[index_of(r.pc1)];
    if (r.v0)
      write_entry(r.pc0, r.t0, r.tgt0, r.k0, hit0, ctr0);
    if (keep1)
      write_entry(r.pc1, r.t1, r.tgt1, r.k1, hit1, ctr1);
    if (r.v0 && r.t0 && (r.k0 == bpu_pkg::BR_CALL || r.k0 == bpu_pkg::BR_RETURN))
      stack_op(r.k0 == bpu_pkg::BR_CALL, r.k0 == bpu_pkg::BR_RETURN, r.pc0 + 32'd4);
    else if (keep1 && r.t1)
      stack_op(r.k1 == bpu_pkg::BR_CALL, r.k1 == bpu_pkg::BR_RETURN, r.pc1 + 32'd4);
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    logic [31:0] pa;
    logic [31:0] pb;
    logic [31:0] ta;
    logic [31:0] tb;
    for (int s = 0; s < 4; s++)
      add_lookup("reset_lookup", 32'h1000 + 4 * s);
    add_report("install", 32'h2024, 1'b1, 32'h3000, bpu_pkg::BR_COND, 1'b1);
    add_lookup("install", 32'h2020);
    add_lookup("install", 32'h2028);
    for (int n = 0; n < 4; n++)
    begin
      add_report("hysteresis", 32'h2024, n >= 2, 32'h3000, bpu_pkg::BR_COND, 1'b0);
      add_lookup("hysteresis", 32'h2020);
    end
    add_report("call_return", 32'h4008, 1'b1, 32'h5000, bpu_pkg::BR_CALL, 1'b1);
    add_report("call_return", 32'h5010, 1'b1, 32'h400c, bpu_pkg::BR_RETURN, 1'b1);
    add_lookup("call_return", 32'h5010);
    add_report("call_return", 32'h4100, 1'b1, 32'h5000, bpu_pkg::BR_CALL, 1'b0);
    add_lookup("call_return", 32'h5010);
    // nine calls into an eight deep stack, then unwind
    for (int n = 0; n < 9; n++)
      add_report("ras_wrap", 32'h6000 + n * 32'h100, 1'b1, 32'h5000, bpu_pkg::BR_CALL, 1'b0);
    for (int n = 0; n < 9; n++)
    begin
      add_lookup("ras_wrap", 32'h5010);
      add_report("ras_wrap", 32'h5010, 1'b1, 32'h400c, bpu_pkg::BR_RETURN, 1'b0);
    end
    add_pair("flush_both", 32'h7000, 1'b1, 32'h7400, bpu_pkg::BR_COND, 1'b1,
             1'b1, 32'h7104, 1'b1, 32'h7800, bpu_pkg::BR_COND, 1'b1);
    add_lookup("flush_both", 32'h7100);
    add_lookup("flush_both", 32'h7000);
    add_report("flush_not_taken", 32'h7200, 1'b0, 32'h0, bpu_pkg::BR_COND, 1'b1);
    add_pair("no_flush", 32'h7000, 1'b1, 32'h7400, bpu_pkg::BR_COND, 1'b0,
             1'b1, 32'h7300, 1'b0, 32'h0, bpu_pkg::BR_COND, 1'b0);
    // same index as the trained 0x2024 entry but another tag
    for (int n = 0; n < 4; n++)
    begin
      rnd = $urandom;
      add_lookup("alias", {rnd[31:16], (rnd[15:8] == 8'h20) ? 8'h21 : rnd[15:8], 8'h20});
    end
    rnd = $urandom;
    pa  = {rnd[31:8], 8'h34};
    rnd = $urandom;
    pb  = {rnd[31:16], pa[15:8] ^ 8'h5a, 8'h34};
    ta  = $urandom & ~32'd3;
    tb  = $urandom & ~32'd3;
    add_pair("same_index", pa, 1'b1, ta, bpu_pkg::BR_COND, 1'b0,
             1'b1, pb, 1'b1, tb, bpu_pkg::BR_JUMP, 1'b0);
    add_lookup("same_index", {pb[31:4], 4'h0});
    add_lookup("same_index", {pa[31:4], 4'h0});
    for (int n = 0; n < 6; n++)
      add_lookup("background", $urandom & ~32'd3);
  endtask

  // stuck run guard
  always @(posedge clk)
  begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit)
    begin
      $display("run stopped: no end after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  initial
  begin
    row_t r;
    fetch_pc       = '0;
    ex0_valid      = 1'b0;
    ex0_pc         = '0;
    ex0_taken      = 1'b0;
    ex0_target     = '0;
    ex0_kind       = bpu_pkg::BR_COND;
    ex0_mispredict = 1'b0;
    ex1_valid      = 1'b0;
    ex1_pc         = '0;
    ex1_taken      = 1'b0;
    ex1_target     = '0;
    ex1_kind       = bpu_pkg::BR_COND;
    ex1_mispredict = 1'b0;
    errors = 0;
    checks = 0;
    tests = 0;
    failed_tests = 0;
    test_errs = 0;
    cycles = 0;
    m_sp = 0;
    m_count = 0;
    for (int e = 0; e < entries; e++)
      m_valid[e] = 1'b0;
    void'($urandom(32'haa8fe6db));
    build_table();
    cycle_limit = 2 * rows.size() + 20;
    @(negedge reset);
    for (int i = 0; i < rows.size(); i++)
    begin
      r = rows[i];
      predict(r.fetch_pc, r.exp_next, r.exp_valid, r.exp_jump);
      r.exp_flush    = (r.v0 && r.m0) || (r.v1 && r.m1);
      r.exp_flush_pc = r.v1 ? (r.t1 ? r.tgt1 : r.pc1 + 32'd4) : 32'd0;
      if (r.v0 && r.m0)
        r.exp_flush_pc = r.t0 ? r.tgt0 : r.pc0 + 32'd4;
      rows[i] = r;
      @(posedge clk);
      fetch_pc       <= r.fetch_pc;
      ex0_valid      <= r.v0;
      ex0_pc         <= r.pc0;
      ex0_taken      <= r.t0;
      ex0_target     <= r.tgt0;
      ex0_kind       <= r.k0;
      ex0_mispredict <= r.m0;
      ex1_valid      <= r.v1;
      ex1_pc         <= r.pc1;
      ex1_taken      <= r.t1;
      ex1_target     <= r.tgt1;
      ex1_kind       <= r.k1;
      ex1_mispredict <= r.m1;
      @(negedge clk);
      compare({names[i], " next_pc"}, r.exp_next, next_pc);
      compare({names[i], " slot_valid"}, {28'h0, r.exp_valid}, {28'h0, slot_valid});
      compare({names[i], " slot_is_jump"}, {28'h0, r.exp_jump}, {28'h0, slot_is_jump});
      compare({names[i], " flush"}, {31'h0, r.exp_flush}, {31'h0, flush});
      if (r.exp_flush)
        compare({names[i], " flush_pc"}, r.exp_flush_pc, flush_pc);
      train(r);
      if (i == rows.size() - 1 || names[i + 1] != names[i])
      begin
        tests++;
        if (test_errs == 0)
          $display("test %s passed", names[i]);
        else
        begin
          $display("test %s failed with %0d errors", names[i], test_errs);
          failed_tests++;
        end
        test_errs = 0;
      end
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests, failed_tests, checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+common
common/bpu_pkg.sv
hw/bpu/bpu_table.sv
hw/bpu/bpu_ras.sv
hw/bpu/bpu_fetch_select.sv
hw/bpu/bpu_resolve.sv
hw/bpu/bpu_top.sv
verif/bpu_clock_gen.sv
verif/bpu_tb.sv
